// File: design/priv_pkg.sv
`default_nettype none

package priv_pkg;

    localparam int TLB_ENTRIES = 8;
    localparam int PAGE_BITS   = 12;

    typedef logic [1:0]  plv_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ADEM,
        EXC_ALE,
        EXC_TLBR,
        EXC_PIL,
        EXC_PIS,
        EXC_PPI,
        EXC_PME
    } excp_code_e;

    typedef struct packed {
        logic e;
        vpn_t vpn;
        ppn_t ppn;
        logic v;
        logic d;
        plv_t plv;
    } tlb_entry_t;

    typedef struct packed {
        logic found;
        ppn_t ppn;
        logic v;
        logic d;
        plv_t plv;
    } tlb_result_t;

endpackage

`default_nettype wire

// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    // 4096 words, word address bits [13:2]
    localparam int DMEM_AW = 12;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [DATA_W/8-1:0] byte_en_t;
    typedef logic [4:0]          reg_idx_t;

    typedef enum logic [3:0] {
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        LL_W,
        SC_W
    } mem_op_e;

    typedef struct packed {
        addr_t    pc;
        mem_op_e  op;
        addr_t    vaddr;
        data_t    store_data;
        reg_idx_t waddr;
    } ex_mem_t;

    typedef struct packed {
        addr_t                pc;
        mem_op_e              op;
        logic [1:0]           addr_lo;
        reg_idx_t             waddr;
        logic                 wreg;
        data_t                wdata;
        logic                 excp;
        priv_pkg::excp_code_e excp_code;
        logic                 access_valid;
        logic                 ll_we;
        logic                 ll_value;
    } mem1_mem2_t;

    typedef struct packed {
        logic     en;
        logic     we;
        addr_t    addr;
        byte_en_t be;
        data_t    wdata;
    } dmem_req_t;

    typedef struct packed {
        addr_t                pc;
        reg_idx_t             waddr;
        logic                 wreg;
        data_t                wdata;
        logic                 excp;
        priv_pkg::excp_code_e excp_code;
    } mem_result_t;

endpackage

`default_nettype wire

// File: design/dtlb.sv
`timescale 1ns/10ps
`default_nettype none

module dtlb (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire logic                                    we_i,
    input  wire logic [$clog2(priv_pkg::TLB_ENTRIES)-1:0] idx_i,
    input  priv_pkg::tlb_entry_t                          entry_i,
    input  priv_pkg::vpn_t                                vpn_i,
    output priv_pkg::tlb_result_t                         result_o
);

    priv_pkg::tlb_entry_t                entries_q [priv_pkg::TLB_ENTRIES];
    logic [priv_pkg::TLB_ENTRIES-1:0]    entry_en_q;

    // Enable bits are the only state that needs reset
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_en_q <= '0;
        end else if (we_i) begin
            entry_en_q[idx_i] <= entry_i.e;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            entries_q[idx_i] <= entry_i;
        end
    end

    // Walk downwards so the lowest matching index wins
    always_comb begin
        result_o = '0;
        for (int i = priv_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_en_q[i] && entries_q[i].vpn == vpn_i) begin
                result_o.found = 1'b1;
                result_o.ppn   = entries_q[i].ppn;
                result_o.v     = entries_q[i].v;
                result_o.d     = entries_q[i].d;
                result_o.plv   = entries_q[i].plv;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem1_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem1_stage (
    input  wire logic           clk,
    input  wire logic           rst,
    input  lsu_pkg::ex_mem_t    ex_i,
    input  wire logic           ex_valid_i,
    output logic                ex_ready_o,
    input  priv_pkg::plv_t      plv_i,
    input  wire logic           trans_en_i,
    output priv_pkg::vpn_t      tlb_vpn_o,
    input  priv_pkg::tlb_result_t tlb_i,
    input  wire logic           llbit_i,
    output lsu_pkg::dmem_req_t  dmem_req_o,
    output lsu_pkg::mem1_mem2_t out_o,
    output logic                out_valid_o,
    input  wire logic           out_ready_i
);

    lsu_pkg::mem1_mem2_t  out_d;
    lsu_pkg::mem1_mem2_t  out_q;
    logic                 out_valid_q;
    logic                 accept;
    lsu_pkg::addr_t       vaddr;
    lsu_pkg::addr_t       paddr;
    logic                 is_store;
    logic                 is_sc;
    logic                 misaligned;
    logic                 llbit_eff;
    logic                 sc_ok;
    priv_pkg::excp_code_e excp_code;
    logic                 excp;

    assign ex_ready_o = !out_valid_q || out_ready_i;
    assign accept     = ex_valid_i && ex_ready_o;

    assign vaddr     = ex_i.vaddr;
    assign tlb_vpn_o = vaddr[lsu_pkg::ADDR_W-1:priv_pkg::PAGE_BITS];
    assign paddr     = trans_en_i ? {tlb_i.ppn, vaddr[priv_pkg::PAGE_BITS-1:0]} : vaddr;

    assign is_sc    = ex_i.op == lsu_pkg::SC_W;
    assign is_store = ex_i.op inside {lsu_pkg::ST_B, lsu_pkg::ST_H, lsu_pkg::ST_W, lsu_pkg::SC_W};

    always_comb begin
        case (ex_i.op)
            lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H: misaligned = vaddr[0];
            lsu_pkg::LD_B, lsu_pkg::LD_BU, lsu_pkg::ST_B: misaligned = 1'b0;
            default:                                      misaligned = |vaddr[1:0];
        endcase
    end

    // An LL or SC still sitting in our register has not reached mem2 yet
    assign llbit_eff = (out_valid_q && out_q.ll_we) ? out_q.ll_value : llbit_i;
    assign sc_ok     = is_sc && llbit_eff;

    // Exception priority
    always_comb begin
        if (trans_en_i && plv_i == 2'd3 && vaddr[lsu_pkg::ADDR_W-1]) begin
            excp_code = priv_pkg::EXC_ADEM;
        end else if (misaligned) begin
            excp_code = priv_pkg::EXC_ALE;
        end else if (trans_en_i && !tlb_i.found) begin
            excp_code = priv_pkg::EXC_TLBR;
        end else if (trans_en_i && !tlb_i.v) begin
            excp_code = is_store ? priv_pkg::EXC_PIS : priv_pkg::EXC_PIL;
        end else if (trans_en_i && plv_i > tlb_i.plv) begin
            excp_code = priv_pkg::EXC_PPI;
        end else if (trans_en_i && is_store && !tlb_i.d) begin
            excp_code = priv_pkg::EXC_PME;
        end else begin
            excp_code = priv_pkg::EXC_NONE;
        end
    end

    assign excp = excp_code != priv_pkg::EXC_NONE;

    // Request only on the accepting edge
    always_comb begin
        dmem_req_o      = '0;
        dmem_req_o.en   = accept && !excp && (!is_sc || sc_ok);
        dmem_req_o.we   = is_store;
        dmem_req_o.addr = paddr;
        case (ex_i.op)
            lsu_pkg::ST_B: begin
                dmem_req_o.be    = 4'b0001 << paddr[1:0];
                dmem_req_o.wdata = {4{ex_i.store_data[7:0]}};
            end
            lsu_pkg::ST_H: begin
                dmem_req_o.be    = 4'b0011 << paddr[1:0];
                dmem_req_o.wdata = {2{ex_i.store_data[15:0]}};
            end
            default: begin
                dmem_req_o.be    = '1;
                dmem_req_o.wdata = ex_i.store_data;
            end
        endcase
    end

    always_comb begin
        out_d              = '0;
        out_d.pc           = ex_i.pc;
        out_d.op           = ex_i.op;
        out_d.addr_lo      = paddr[1:0];
        out_d.waddr        = ex_i.waddr;
        out_d.wreg         = !is_store || is_sc;
        out_d.excp         = excp;
        out_d.excp_code    = excp_code;
        out_d.access_valid = !excp;
        if (is_sc) begin
            // SC result is the success flag
            out_d.wdata = {{(lsu_pkg::DATA_W-1){1'b0}}, llbit_eff};
        end
        if (!excp && ex_i.op == lsu_pkg::LL_W) begin
            out_d.ll_we    = 1'b1;
            out_d.ll_value = 1'b1;
        end else if (!excp && sc_ok) begin
            out_d.ll_we    = 1'b1;
            out_d.ll_value = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (ex_ready_o) begin
            out_valid_q <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_q <= out_d;
        end
    end

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

// File: design/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem (
    input  wire logic          clk,
    input  wire logic          rst,
    input  lsu_pkg::dmem_req_t req_i,
    output lsu_pkg::data_t     rdata_o
);

    localparam int DEPTH = 2 ** lsu_pkg::DMEM_AW;

    lsu_pkg::data_t                mem [DEPTH];
    logic [lsu_pkg::DMEM_AW-1:0]   idx;
    lsu_pkg::data_t                rdata_q;

    // Word index wraps at the array depth
    assign idx = req_i.addr[lsu_pkg::DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (req_i.en && req_i.we) begin
            for (int b = 0; b < lsu_pkg::DATA_W / 8; b++) begin
                if (req_i.be[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // Read word held until the next request
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (req_i.en) begin
            rdata_q <= mem[idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/mem2_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem2_stage (
    input  wire logic            clk,
    input  wire logic            rst,
    input  lsu_pkg::mem1_mem2_t  in_i,
    input  wire logic            in_valid_i,
    output logic                 in_ready_o,
    input  lsu_pkg::data_t       rdata_i,
    output logic                 llbit_o,
    output lsu_pkg::mem_result_t result_o,
    output logic                 result_valid_o,
    input  wire logic            result_ready_i
);

    localparam int DW = lsu_pkg::DATA_W;

    lsu_pkg::mem_result_t res_d;
    lsu_pkg::mem_result_t res_q;
    logic                 res_valid_q;
    logic                 accept;
    logic                 llbit_q;
    lsu_pkg::data_t       shifted;
    lsu_pkg::data_t       load_data;

    assign in_ready_o = !res_valid_q || result_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    // Bring the addressed lane down to bit 0
    assign shifted = rdata_i >> {in_i.addr_lo, 3'b000};

    always_comb begin
        case (in_i.op)
            lsu_pkg::LD_B:  load_data = {{(DW-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::LD_BU: load_data = {{(DW-8){1'b0}}, shifted[7:0]};
            lsu_pkg::LD_H:  load_data = {{(DW-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::LD_HU: load_data = {{(DW-16){1'b0}}, shifted[15:0]};
            lsu_pkg::LD_W,
            lsu_pkg::LL_W:  load_data = rdata_i;
            // Stores and SC keep what mem1 decided
            default:        load_data = in_i.wdata;
        endcase
    end

    always_comb begin
        res_d           = '0;
        res_d.pc        = in_i.pc;
        res_d.waddr     = in_i.waddr;
        res_d.excp      = in_i.excp;
        res_d.excp_code = in_i.excp_code;
        if (in_i.access_valid) begin
            res_d.wreg  = in_i.wreg;
            res_d.wdata = load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid_q <= 1'b0;
            llbit_q     <= 1'b0;
        end else begin
            if (in_ready_o) begin
                res_valid_q <= in_valid_i;
            end
            if (accept && in_i.ll_we) begin
                llbit_q <= in_i.ll_value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_q <= res_d;
        end
    end

    assign llbit_o        = llbit_q;
    assign result_o       = res_q;
    assign result_valid_o = res_valid_q;

endmodule

`default_nettype wire

// File: design/mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  lsu_pkg::ex_mem_t                              ex_i,
    input  wire logic                                    ex_valid_i,
    output logic                                          ex_ready_o,
    input  priv_pkg::plv_t                                plv_i,
    input  wire logic                                    trans_en_i,
    input  wire logic                                    tlb_we_i,
    input  wire logic [$clog2(priv_pkg::TLB_ENTRIES)-1:0] tlb_idx_i,
    input  priv_pkg::tlb_entry_t                          tlb_entry_i,
    output lsu_pkg::mem_result_t                          result_o,
    output logic                                          result_valid_o,
    input  wire logic                                    result_ready_i
);

    priv_pkg::vpn_t        tlb_vpn;
    priv_pkg::tlb_result_t tlb_res;
    lsu_pkg::dmem_req_t    dmem_req;
    lsu_pkg::data_t        dmem_rdata;
    lsu_pkg::mem1_mem2_t   m1_out;
    logic                  m1_valid;
    logic                  m2_ready;
    logic                  llbit;

    dtlb dtlb_i (
        .clk      (clk),
        .rst      (rst),
        .we_i     (tlb_we_i),
        .idx_i    (tlb_idx_i),
        .entry_i  (tlb_entry_i),
        .vpn_i    (tlb_vpn),
        .result_o (tlb_res)
    );

    mem1_stage mem1_stage_i (
        .clk         (clk),
        .rst         (rst),
        .ex_i        (ex_i),
        .ex_valid_i  (ex_valid_i),
        .ex_ready_o  (ex_ready_o),
        .plv_i       (plv_i),
        .trans_en_i  (trans_en_i),
        .tlb_vpn_o   (tlb_vpn),
        .tlb_i       (tlb_res),
        .llbit_i     (llbit),
        .dmem_req_o  (dmem_req),
        .out_o       (m1_out),
        .out_valid_o (m1_valid),
        .out_ready_i (m2_ready)
    );

    data_mem data_mem_i (
        .clk     (clk),
        .rst     (rst),
        .req_i   (dmem_req),
        .rdata_o (dmem_rdata)
    );

    mem2_stage mem2_stage_i (
        .clk            (clk),
        .rst            (rst),
        .in_i           (m1_out),
        .in_valid_i     (m1_valid),
        .in_ready_o     (m2_ready),
        .rdata_i        (dmem_rdata),
        .llbit_o        (llbit),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

endmodule

`default_nettype wire

// File: dv/mem_subsys_properties.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_properties (
    input wire logic           clk,
    input wire logic           rst,
    input wire logic           ex_valid_i,
    input wire logic           ex_ready_o,
    input lsu_pkg::mem_result_t result_o,
    input wire logic           result_valid_o,
    input wire logic           result_ready_i
);

    // Output register empties on reset
    valid_low_after_reset: assert property (@(posedge clk) rst |=> !result_valid_o)
        else $error("result_valid_o high in the cycle after reset");

    // Stalled result must not move
    result_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
        else $error("result changed or dropped while stalled");

    // Two stages, two cycles with the consumer always ready
    fixed_latency: assert property (@(posedge clk) disable iff (rst)
        (ex_valid_i && ex_ready_o && result_ready_i) ##1 result_ready_i |-> ##1 result_valid_o)
        else $error("result_valid_o missing two cycles after an accepted transfer");

endmodule

bind mem_subsys_top mem_subsys_properties mem_subsys_properties_i (
    .clk            (clk),
    .rst            (rst),
    .ex_valid_i     (ex_valid_i),
    .ex_ready_o     (ex_ready_o),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
);

`default_nettype wire

// File: dv/mem_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb;

    localparam int RAND_N    = 300;
    localparam int CYCLE_LIM = (RAND_N + 120) * 4 + 500;

    logic                  clk;
    logic                  rst;
    lsu_pkg::ex_mem_t      ex_i;
    logic                  ex_valid_i;
    logic                  ex_ready_o;
    priv_pkg::plv_t        plv_i;
    logic                  trans_en_i;
    logic                  tlb_we_i;
    logic [2:0]            tlb_idx_i;
    priv_pkg::tlb_entry_t  tlb_entry_i;
    lsu_pkg::mem_result_t  result_o;
    logic                  result_valid_o;
    logic                  result_ready_i;

    lsu_pkg::data_t        smem [4096];
    priv_pkg::tlb_entry_t  stlb [8];
    logic                  sllbit;
    lsu_pkg::mem_result_t  exp_q [$];
    lsu_pkg::mem_result_t  exp_r;
    logic [15:0]           lfsr_q;
    logic                  rand_ready;
    lsu_pkg::addr_t        pc;
    int                    val_errs;
    int                    other_errs;
    int                    cycles;

    mem_subsys_top mem_subsys_top_i (.*);

    always #2 clk = ~clk;

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // Expected result from the shadow TLB, memory and LL bit
    task automatic predict(lsu_pkg::mem_op_e op, lsu_pkg::addr_t va, lsu_pkg::data_t sd);
        lsu_pkg::mem_result_t r;
        priv_pkg::tlb_entry_t hit;
        logic                 found;
        logic                 st;
        logic                 mis;
        lsu_pkg::addr_t       pa;
        lsu_pkg::data_t       w;
        int                   idx;
        int                   lane;
        found = 1'b0;
        hit   = '0;
        for (int i = 0; i < 8; i++) begin
            if (!found && stlb[i].e && stlb[i].vpn == va[31:12]) begin
                found = 1'b1;
                hit   = stlb[i];
            end
        end
        pa   = trans_en_i ? {hit.ppn, va[11:0]} : va;
        idx  = int'(pa[13:2]);
        lane = int'(pa[1:0]);
        st   = op inside {lsu_pkg::ST_B, lsu_pkg::ST_H, lsu_pkg::ST_W, lsu_pkg::SC_W};
        mis  = (op inside {lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H}) ? va[0] :
               (op inside {lsu_pkg::LD_B, lsu_pkg::LD_BU, lsu_pkg::ST_B}) ? 1'b0 : |va[1:0];
        r = '0;
        r.pc    = pc;
        r.waddr = pc[6:2];
        if (trans_en_i && plv_i == 2'd3 && va[31]) r.excp_code = priv_pkg::EXC_ADEM;
        else if (mis) r.excp_code = priv_pkg::EXC_ALE;
        else if (trans_en_i && !found) r.excp_code = priv_pkg::EXC_TLBR;
        else if (trans_en_i && !hit.v) r.excp_code = st ? priv_pkg::EXC_PIS : priv_pkg::EXC_PIL;
        else if (trans_en_i && plv_i > hit.plv) r.excp_code = priv_pkg::EXC_PPI;
        else if (trans_en_i && st && !hit.d) r.excp_code = priv_pkg::EXC_PME;
        else r.excp_code = priv_pkg::EXC_NONE;
        r.excp = r.excp_code != priv_pkg::EXC_NONE;
        w = smem[idx];
        if (!r.excp) begin
            r.wreg = !st || op == lsu_pkg::SC_W;
            case (op)
                lsu_pkg::LD_B:  r.wdata = 32'($signed(w[lane*8 +: 8]));
                lsu_pkg::LD_BU: r.wdata = 32'(w[lane*8 +: 8]);
                lsu_pkg::LD_H:  r.wdata = 32'($signed(w[lane*8 +: 16]));
                lsu_pkg::LD_HU: r.wdata = 32'(w[lane*8 +: 16]);
                lsu_pkg::ST_B:  smem[idx][lane*8 +: 8] = sd[7:0];
                lsu_pkg::ST_H:  smem[idx][lane*8 +: 16] = sd[15:0];
                lsu_pkg::ST_W:  smem[idx] = sd;
                lsu_pkg::LL_W: begin
                    r.wdata = w;
                    sllbit  = 1'b1;
                end
                lsu_pkg::SC_W: begin
                    r.wdata = {31'd0, sllbit};
                    if (sllbit) begin
                        smem[idx] = sd;
                        sllbit    = 1'b0;
                    end
                end
                default: r.wdata = w;
            endcase
        end
        exp_q.push_back(r);
    endtask

    // Holds the instruction until accepted; valid stays up for the next call
    task automatic issue(lsu_pkg::mem_op_e op, lsu_pkg::addr_t va, lsu_pkg::data_t sd);
        @(negedge clk);
        pc               = pc + 4;
        ex_i.pc          = pc;
        ex_i.op          = op;
        ex_i.vaddr       = va;
        ex_i.store_data  = sd;
        ex_i.waddr       = pc[6:2];
        ex_valid_i       = 1'b1;
        #1;
        while (!ex_ready_o) begin
            @(negedge clk);
            #1;
        end
        predict(op, va, sd);
    endtask

    task automatic set_mode(logic trans, priv_pkg::plv_t plv);
        @(negedge clk);
        ex_valid_i = 1'b0;
        trans_en_i = trans;
        plv_i      = plv;
    endtask

    task automatic fill_tlb(int idx, priv_pkg::vpn_t vpn, priv_pkg::ppn_t ppn,
                            logic v, logic d, priv_pkg::plv_t plv);
        @(negedge clk);
        ex_valid_i  = 1'b0;
        tlb_we_i    = 1'b1;
        tlb_idx_i   = 3'(idx);
        tlb_entry_i = {1'b1, vpn, ppn, v, d, plv};
        stlb[idx]   = tlb_entry_i;
        @(negedge clk);
        tlb_we_i    = 1'b0;
    endtask

    task automatic compare_field(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            val_errs++;
            $display("error t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        result_ready_i <= rand_ready ? lfsr_bit() : 1'b1;
    end

    always @(posedge clk) begin
        if (!rst && result_valid_o && result_ready_i) begin
            assert (exp_q.size() > 0) else begin
                other_errs++;
                $display("result appeared at %0t with no instruction outstanding", $time);
            end
            if (exp_q.size() > 0) begin
                exp_r = exp_q.pop_front();
                compare_field("result_o.pc", result_o.pc, exp_r.pc);
                compare_field("result_o.waddr", 32'(result_o.waddr), 32'(exp_r.waddr));
                compare_field("result_o.wreg", 32'(result_o.wreg), 32'(exp_r.wreg));
                compare_field("result_o.wdata", result_o.wdata, exp_r.wdata);
                compare_field("result_o.excp", 32'(result_o.excp), 32'(exp_r.excp));
                compare_field("result_o.excp_code", 32'(result_o.excp_code),
                              32'(exp_r.excp_code));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIM) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIM);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        lsu_pkg::mem_op_e op;
        lsu_pkg::addr_t   a;
        clk            = 0;
        rst            = 1;
        ex_i           = '0;
        ex_valid_i     = 0;
        plv_i          = '0;
        trans_en_i     = 0;
        tlb_we_i       = 0;
        tlb_idx_i      = '0;
        tlb_entry_i    = '0;
        result_ready_i = 1;
        lfsr_q         = 16'd75;
        rand_ready     = 0;
        pc             = 32'h1c00_0000;
        sllbit         = 0;
        val_errs       = 0;
        other_errs     = 0;
        cycles         = 0;
        for (int i = 0; i < 8; i++) begin
            stlb[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 0;

        // Every lane width and both extensions
        issue(lsu_pkg::ST_W, 32'h100, 32'h8899_aabb);
        for (int l = 0; l < 4; l++) issue(lsu_pkg::ST_B, 32'h100 + l, 32'h7f + 32'(l) * 8'h40);
        for (int l = 0; l < 4; l++) begin
            issue(lsu_pkg::LD_B, 32'h100 + l, '0);
            issue(lsu_pkg::LD_BU, 32'h100 + l, '0);
        end
        issue(lsu_pkg::ST_H, 32'h104, 32'h0000_8123);
        issue(lsu_pkg::ST_H, 32'h106, 32'h0000_7abc);
        for (int l = 0; l < 4; l += 2) begin
            issue(lsu_pkg::LD_H, 32'h104 + l, '0);
            issue(lsu_pkg::LD_HU, 32'h104 + l, '0);
        end
        issue(lsu_pkg::LD_W, 32'h100, '0);
        issue(lsu_pkg::LD_W, 32'h104, '0);

        // Two pages aliasing one frame plus fault entries
        fill_tlb(0, 20'h00010, 20'h00002, 1, 1, 2'd3);
        fill_tlb(1, 20'h00020, 20'h00002, 1, 1, 2'd3);
        fill_tlb(2, 20'h00040, 20'h00002, 0, 1, 2'd3);
        fill_tlb(3, 20'h00050, 20'h00002, 1, 1, 2'd0);
        fill_tlb(4, 20'h00060, 20'h00002, 1, 0, 2'd3);
        set_mode(1, 2'd0);
        issue(lsu_pkg::ST_W, 32'h0001_0040, 32'h1234_5678);
        issue(lsu_pkg::LD_W, 32'h0002_0040, '0);
        issue(lsu_pkg::LD_W, 32'h0003_0000, '0);
        issue(lsu_pkg::LD_W, 32'h0001_0042, '0);
        issue(lsu_pkg::LD_H, 32'h0003_0001, '0);
        issue(lsu_pkg::LD_W, 32'h0004_0040, '0);
        issue(lsu_pkg::ST_W, 32'h0004_0040, 32'hdead_0001);
        issue(lsu_pkg::ST_W, 32'h0006_0040, 32'hdead_0002);
        issue(lsu_pkg::LD_W, 32'h0001_0040, '0);
        set_mode(1, 2'd3);
        issue(lsu_pkg::LD_W, 32'h8001_0000, '0);
        issue(lsu_pkg::LD_W, 32'h8001_0001, '0);
        issue(lsu_pkg::LD_W, 32'h0005_0040, '0);
        set_mode(0, 2'd3);
        issue(lsu_pkg::ST_W, 32'h8000_0200, 32'h0bad_f00d);
        issue(lsu_pkg::LD_W, 32'h8000_0200, '0);

        // LL/SC pairs with the last one back to back
        set_mode(0, 2'd0);
        issue(lsu_pkg::ST_W, 32'h300, 32'h1111_1111);
        issue(lsu_pkg::LL_W, 32'h300, '0);
        // Idle cycle so the SC sees the LL bit from mem2
        set_mode(0, 2'd0);
        issue(lsu_pkg::SC_W, 32'h300, 32'h2222_2222);
        issue(lsu_pkg::SC_W, 32'h300, 32'h3333_3333);
        issue(lsu_pkg::LD_W, 32'h300, '0);
        issue(lsu_pkg::LL_W, 32'h300, '0);
        issue(lsu_pkg::SC_W, 32'h300, 32'h4444_4444);
        issue(lsu_pkg::LD_W, 32'h300, '0);

        // Random stream over a small pre-filled window
        for (int i = 0; i < 16; i++) issue(lsu_pkg::ST_W, 32'h400 + 32'(i) * 4, rand_bits(32));
        rand_ready = 1'b1;
        for (int i = 0; i < RAND_N; i++) begin
            op = lsu_pkg::mem_op_e'(4'(rand_bits(4) % 10));
            a  = 32'h400 + rand_bits(6);
            issue(op, a, rand_bits(32));
        end
        rand_ready = 1'b0;
        set_mode(0, 2'd0);
        // Pipeline empties within a few cycles once ready stays high
        for (int i = 0; i < 16 && exp_q.size() > 0; i++) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        assert (exp_q.size() == 0) else begin
            other_errs++;
            $display("results missing at the end of the run");
        end
        $display("errors: %0d total, %0d value mismatches, %0d other",
                 val_errs + other_errs, val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
design/priv_pkg.sv
design/lsu_pkg.sv
design/dtlb.sv
design/mem1_stage.sv
design/data_mem.sv
design/mem2_stage.sv
design/mem_subsys_top.sv
dv/mem_subsys_properties.sv
dv/mem_subsys_tb.sv

// File: run.sh
#!/bin/bash
# Build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mem_subsys_tb -f flist.f \
    -o sim_mem_subsys > build.log 2>&1 \
    && ./obj_dir/sim_mem_subsys > sim.log 2>&1 \
    || echo "build or simulation returned an error"
grep -q "^TB PASSED$" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
